// File: compile.f
+incdir+include
hw/ddc_cfg_pkg.sv
hw/ddc_sample_pkg.sv
hw/ddc_settings.sv
hw/rate_control_fsm.sv
hw/decim_counter.sv
hw/iq_input_mux.sv
hw/cic_decimator.sv
hw/output_scaler.sv
hw/ddc_top.sv
verification/tb_ddc.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_ddc \
  -f compile.f \
  -o tb_ddc

sim_out=$(./obj_dir/tb_ddc)
echo "$sim_out"

if echo "$sim_out" | grep -qF '>>> PASS'; then
  exit 0
else
  exit 1
fi

// File: verification/tb_ddc.sv
// ====================
// drives ddc_top with settings writes and sample streams
// expected words come from a moving sum model of the chain
// the chain must be drained before scale or rate changes
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "ddc_consts.svh"

module tb_ddc
  import ddc_cfg_pkg::*;
();

  localparam int TOTAL_SAMPLES   = 511;
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 20 + 2000;  // margin for setup and drain

  logic        clk;
  logic        reset;
  logic        i_clear;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic        i_in_stb;
  logic        i_in_last;
  logic [31:0] i_in_sample;
  wire         o_out_stb;
  wire         o_out_last;
  wire  [31:0] o_out_sample;

  integer      seed;
  logic [32:0] exp_q[$];  // {last, I, Q}
  longint      hist_i[$];
  longint      hist_q[$];
  int          cur_rate;
  longint      cur_scale;
  bit          swap_on;
  bit          real_on;
  int          win_cnt;
  bit          win_last;
  int          errors;
  int          checks;
  int          out_seen;
  int          exp_count;
  int          err_start;

  ddc_top dut (
    .clk          (clk),
    .reset        (reset),
    .i_clear      (i_clear),
    .i_set_stb    (i_set_stb),
    .i_set_addr   (i_set_addr),
    .i_set_data   (i_set_data),
    .i_in_stb     (i_in_stb),
    .i_in_last    (i_in_last),
    .i_in_sample  (i_in_sample),
    .o_out_stb    (o_out_stb),
    .o_out_last   (o_out_last),
    .o_out_sample (o_out_sample)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic longint saturate(input longint v, input int bits);
    longint hi;
    longint lo;
    hi = (longint'(1) << (bits - 1)) - 1;
    lo = -(longint'(1) << (bits - 1));
    if (v > hi) return hi;
    if (v < lo) return lo;
    return v;
  endfunction

  function automatic int ceil_log2(input int r);
    int k;
    k = 0;
    while ((1 << k) < r) begin
      k++;
    end
    return k;
  endfunction

  // cascaded length r moving sums from a zero state, then the output rules
  function automatic longint ref_rail(input longint x[$], input int r, input longint scale);
    longint cur[$];
    longint nxt[$];
    longint acc;
    longint v;
    cur = x;
    for (int st = 0; st < `DDC_CIC_N; st++) begin
      nxt.delete();
      acc = 0;
      for (int n = 0; n < cur.size(); n++) begin
        acc += cur[n];
        if (n >= r) begin
          acc -= cur[n - r];
        end
        nxt.push_back(acc);
      end
      cur = nxt;
    end
    v = cur[cur.size() - 1];
    v = saturate(v >>> (`DDC_CIC_N * ceil_log2(r)), `DDC_SAMPLE_W);
    v = saturate((v * scale) >>> `DDC_SCALE_SHIFT, `DDC_SAMPLE_W);
    v = saturate((v + 128) >>> (`DDC_SAMPLE_W - `DDC_OUT_W), `DDC_OUT_W);
    return v;
  endfunction

  task automatic model_reset(input int rate);
    hist_i.delete();
    hist_q.delete();
    win_cnt  = 0;
    win_last = 1'b0;
    cur_rate = (rate == 0) ? 1 : rate;
  endtask

  task automatic quiet_inputs();
    i_in_stb  = 1'b0;
    i_in_last = 1'b0;
    i_set_stb = 1'b0;
    i_clear   = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      quiet_inputs();
    end
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    quiet_inputs();
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    case (addr)
      ADDR_SCALE: cur_scale = longint'($signed(data[`DDC_SCALE_W-1:0]));
      ADDR_MUX: begin
        swap_on = data[0];
        real_on = data[1];
      end
      default: ;  // rate is tracked by the callers
    endcase
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    #1;
    quiet_inputs();
    i_clear = 1'b1;
  endtask

  task automatic set_rate(input int rate);
    write_reg(ADDR_DECIM, 32'(rate));
    pulse_clear();
    idle(4);  // apply pulse lands here
    model_reset(rate);
  endtask

  task automatic send_sample(input logic [31:0] smp, input bit last);
    longint hi_r;
    longint lo_r;
    longint ei;
    longint eq;
    @(posedge clk);
    #1;
    quiet_inputs();
    i_in_stb    = 1'b1;
    i_in_last   = last;
    i_in_sample = smp;
    hi_r = longint'($signed(smp[31:16])) * 256;  // 8 zero bits below
    lo_r = longint'($signed(smp[15:0])) * 256;
    hist_i.push_back(swap_on ? lo_r : hi_r);
    hist_q.push_back(real_on ? longint'(0) : (swap_on ? hi_r : lo_r));
    win_last = win_last || last;
    win_cnt++;
    if (win_cnt == cur_rate) begin
      ei = ref_rail(hist_i, cur_rate, cur_scale);
      eq = ref_rail(hist_q, cur_rate, cur_scale);
      exp_q.push_back({win_last, ei[15:0], eq[15:0]});
      exp_count++;
      win_cnt  = 0;
      win_last = 1'b0;
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    idle(1);
    while (exp_q.size() != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    idle(8);  // room for stray words after the last expected one
  endtask

  task automatic begin_test();
    err_start = errors;
    out_seen  = 0;
    exp_count = 0;
  endtask

  task automatic end_test(input string name);
    drain_outputs();
    if (exp_q.size() != 0) begin
      $display("%s: %0d expected output words never arrived", name, exp_q.size());
      errors++;
      exp_q.delete();
    end
    if (out_seen != exp_count) begin
      $display("%s: saw %0d output words but expected %0d", name, out_seen, exp_count);
      errors++;
    end
    $display("test %s finished: %0d words, %0d errors", name, out_seen, errors - err_start);
  endtask

  // outputs are sampled mid cycle, away from the clock edge
  initial begin : compare
    logic [32:0] exp_w;
    forever begin
      @(negedge clk);
      if (o_out_stb === 1'b1) begin
        out_seen++;
        if (exp_q.size() == 0) begin
          $display("unexpected output word %h at %0t ns", o_out_sample, $time);
          errors++;
        end else begin
          exp_w = exp_q.pop_front();
          checks++;
          if (o_out_sample !== exp_w[31:0]) begin
            $display("[ERROR] %0t ns o_out_sample got %h expected %h",
                     $time, o_out_sample, exp_w[31:0]);
            errors++;
          end
          if (o_out_last !== exp_w[32]) begin
            $display("[ERROR] %0t ns o_out_last got %b expected %b",
                     $time, o_out_last, exp_w[32]);
            errors++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : main
    bit lst;
    seed   = 90;
    errors = 0;
    checks = 0;
    reset  = 1'b1;
    quiet_inputs();
    i_set_addr  = '0;
    i_set_data  = '0;
    i_in_sample = '0;
    cur_scale   = 0;
    swap_on     = 1'b0;
    real_on     = 1'b0;
    model_reset(`DDC_RATE_RESET);
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    begin_test();
    write_reg(ADDR_SCALE, 32'd16384);  // unity gain
    set_rate(1);
    repeat (64) send_sample($random(seed), 1'b0);
    end_test("unity at rate 1");

    begin_test();
    write_reg(ADDR_MUX, 32'd1);
    repeat (16) send_sample($random(seed), 1'b0);
    write_reg(ADDR_MUX, 32'd2);
    repeat (16) send_sample($random(seed), 1'b0);
    write_reg(ADDR_MUX, 32'd0);
    end_test("swap and real mode");

    begin_test();
    set_rate(4);
    repeat (64) send_sample($random(seed), 1'b0);
    end_test("rate 4");

    begin_test();
    set_rate(37);
    repeat (222) send_sample($random(seed), 1'b0);
    end_test("rate 37");

    // new rate written mid stream must wait for clear
    begin_test();
    set_rate(4);
    repeat (16) send_sample($random(seed), 1'b0);
    write_reg(ADDR_DECIM, 32'd2);
    repeat (16) send_sample($random(seed), 1'b0);
    drain_outputs();
    pulse_clear();
    idle(4);
    model_reset(2);
    repeat (16) send_sample($random(seed), 1'b0);
    end_test("rate change held until clear");

    begin_test();
    write_reg(ADDR_SCALE, 32'd131071);
    set_rate(1);
    repeat (4) begin
      send_sample(32'h7fff_7fff, 1'b0);
      send_sample(32'h8000_8000, 1'b0);
    end
    send_sample(32'h7fff_8000, 1'b0);
    drain_outputs();
    write_reg(ADDR_SCALE, 32'd0);
    repeat (8) send_sample($random(seed), 1'b0);
    end_test("saturation and zero scale");

    begin_test();
    write_reg(ADDR_SCALE, 32'd16384);
    set_rate(4);
    for (int k = 0; k < 16; k++) begin
      for (int j = 0; j < 4; j++) begin
        lst = (j == 3) && ((k % 3 == 1) || (($random(seed) & 7) == 0));
        send_sample($random(seed), lst);
      end
    end
    end_test("last flag");

    idle(4);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/ddc_top.sv
// ====================
// decimating receive path, one sample per clock, no back-pressure
// output follows the window closing input by 6 cycles
// clear does not touch the settings registers
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "ddc_consts.svh"

module ddc_top
  import ddc_cfg_pkg::*;
  import ddc_sample_pkg::*;
(
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    i_clear,
  input  wire                    i_set_stb,
  input  wire [7:0]              i_set_addr,
  input  wire [31:0]             i_set_data,
  input  wire                    i_in_stb,
  input  wire                    i_in_last,
  input  wire [2*`DDC_IN_W-1:0]  i_in_sample,
  output wire                    o_out_stb,
  output wire                    o_out_last,
  output wire [2*`DDC_OUT_W-1:0] o_out_sample  // I upper, Q lower
);

  scale_t scale;
  rate_t  rate_req;
  rate_t  rate;
  wire    rate_written;
  wire    rate_apply;
  wire    swap_iq;
  wire    real_mode;
  wire    mux_stb;
  wire    mux_last;
  rail_t  mux_i;
  rail_t  mux_q;
  wire    dump;
  wire    cic_stb;
  wire    cic_last;
  rail_t  cic_i;
  rail_t  cic_q;

  ddc_settings u_settings (
    .clk            (clk),
    .reset          (reset),
    .i_set_stb      (i_set_stb),
    .i_set_addr     (reg_addr_e'(i_set_addr)),
    .i_set_data     (i_set_data),
    .o_scale        (scale),
    .o_rate_req     (rate_req),
    .o_rate_written (rate_written),
    .o_swap_iq      (swap_iq),
    .o_real_mode    (real_mode)
  );

  rate_control_fsm u_rate_ctrl (
    .clk            (clk),
    .reset          (reset),
    .i_clear        (i_clear),
    .i_in_stb       (i_in_stb),
    .i_rate_written (rate_written),
    .i_rate_req     (rate_req),
    .o_rate_apply   (rate_apply),
    .o_rate         (rate)
  );

  iq_input_mux u_mux (
    .clk         (clk),
    .reset       (reset),
    .i_clear     (i_clear),
    .i_stb       (i_in_stb),
    .i_last      (i_in_last),
    .i_sample    (i_in_sample),
    .i_swap_iq   (swap_iq),
    .i_real_mode (real_mode),
    .o_stb       (mux_stb),
    .o_last      (mux_last),
    .o_i         (mux_i),
    .o_q         (mux_q)
  );

  decim_counter u_decim_cnt (
    .clk          (clk),
    .reset        (reset),
    .i_clear      (i_clear),
    .i_stb        (mux_stb),  // counts mux samples so dump lines up with the cic input
    .i_rate_apply (rate_apply),
    .i_rate       (rate),
    .o_dump       (dump)
  );

  cic_decimator u_cic (
    .clk          (clk),
    .reset        (reset),
    .i_clear      (i_clear),
    .i_stb        (mux_stb),
    .i_last       (mux_last),
    .i_dump       (dump),
    .i_i          (mux_i),
    .i_q          (mux_q),
    .i_rate_apply (rate_apply),
    .i_rate       (rate),
    .o_stb        (cic_stb),
    .o_last       (cic_last),
    .o_i          (cic_i),
    .o_q          (cic_q)
  );

  output_scaler u_scaler (
    .clk     (clk),
    .reset   (reset),
    .i_clear (i_clear),
    .i_stb   (cic_stb),
    .i_last  (cic_last),
    .i_i     (cic_i),
    .i_q     (cic_q),
    .i_scale (scale),
    .o_stb   (o_out_stb),
    .o_last  (o_out_last),
    .o_i     (o_out_sample[2*`DDC_OUT_W-1:`DDC_OUT_W]),
    .o_q     (o_out_sample[`DDC_OUT_W-1:0])
  );

endmodule

`default_nettype wire

// File: hw/output_scaler.sv
// ====================
// multiply, clip to 24 bits, round to 16 bits, 3 cycles
// scale 16384 is unity gain
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "ddc_consts.svh"

module output_scaler
  import ddc_sample_pkg::*;
(
  input  wire       clk,
  input  wire       reset,
  input  wire       i_clear,
  input  wire       i_stb,
  input  wire       i_last,
  input  wire rail_t  i_i,
  input  wire rail_t  i_q,
  input  wire scale_t i_scale,
  output logic      o_stb,
  output logic      o_last,
  output out_rail_t o_i,
  output out_rail_t o_q
);

  localparam int PROD_W = `DDC_SAMPLE_W + `DDC_SCALE_W;
  localparam int DROP_W = `DDC_SAMPLE_W - `DDC_OUT_W;  // bits removed by rounding

  typedef logic signed [PROD_W-1:0]      prod_t;
  typedef logic signed [`DDC_SAMPLE_W:0] rnd_t;

  localparam rail_t     RAIL_MIN = {1'b1, {(`DDC_SAMPLE_W-1){1'b0}}};
  localparam rail_t     RAIL_MAX = ~RAIL_MIN;
  localparam out_rail_t OUT_MIN  = {1'b1, {(`DDC_OUT_W-1){1'b0}}};
  localparam out_rail_t OUT_MAX  = ~OUT_MIN;
  localparam rnd_t      RND_HALF = rnd_t'(1) <<< (DROP_W - 1);

  rail_t     in_rail  [2];
  prod_t     prod     [2];
  prod_t     prod_sh  [2];
  rail_t     clip     [2];
  rail_t     clip_nxt [2];
  rnd_t      rnd_sum  [2];
  out_rail_t rnd_nxt  [2];
  logic      stb1;
  logic      stb2;
  logic      last1;
  logic      last2;

  assign in_rail[0] = i_i;
  assign in_rail[1] = i_q;

  always_comb begin
    for (int r = 0; r < 2; r++) begin
      prod_sh[r] = prod[r] >>> `DDC_SCALE_SHIFT;
      if (&prod_sh[r][PROD_W-1:`DDC_SAMPLE_W-1] || ~|prod_sh[r][PROD_W-1:`DDC_SAMPLE_W-1]) begin
        clip_nxt[r] = prod_sh[r][`DDC_SAMPLE_W-1:0];
      end else begin
        clip_nxt[r] = prod_sh[r][PROD_W-1] ? RAIL_MIN : RAIL_MAX;
      end
      rnd_sum[r] = rnd_t'(clip[r]) + RND_HALF;  // round half up
      if (rnd_sum[r][`DDC_SAMPLE_W] == rnd_sum[r][`DDC_SAMPLE_W-1]) begin
        rnd_nxt[r] = rnd_sum[r][`DDC_SAMPLE_W-1:DROP_W];
      end else begin
        rnd_nxt[r] = rnd_sum[r][`DDC_SAMPLE_W] ? OUT_MIN : OUT_MAX;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      stb1   <= 1'b0;
      stb2   <= 1'b0;
      o_stb  <= 1'b0;
      last1  <= 1'b0;
      last2  <= 1'b0;
      o_last <= 1'b0;
    end else begin
      stb1   <= i_stb;
      stb2   <= stb1;
      o_stb  <= stb2;
      last1  <= i_stb && i_last;
      last2  <= last1;
      o_last <= last2;
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < 2; r++) begin
      if (i_stb) begin
        prod[r] <= prod_t'(in_rail[r]) * prod_t'(i_scale);
      end
      if (stb1) begin
        clip[r] <= clip_nxt[r];
      end
    end
    if (stb2) begin
      o_i <= rnd_nxt[0];
      o_q <= rnd_nxt[1];
    end
  end

  // fixed latency, the top level timing relies on it
  assert property (@(posedge clk) disable iff (reset || i_clear) i_stb |-> ##3 o_stb);
  assert property (@(posedge clk) disable iff (reset || i_clear) !i_stb |-> ##3 !o_stb);

endmodule

`default_nettype wire

// File: hw/cic_decimator.sv
// ====================
// four stage cic on both rails, output 2 cycles after the dump sample
// gain is removed by a shift of 4*ceil(log2 R), so non power of 2 rates lose level
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "ddc_consts.svh"

module cic_decimator
  import ddc_sample_pkg::*;
(
  input  wire   clk,
  input  wire   reset,
  input  wire   i_clear,
  input  wire   i_stb,
  input  wire   i_last,
  input  wire   i_dump,
  input  wire rail_t i_i,
  input  wire rail_t i_q,
  input  wire   i_rate_apply,
  input  wire rate_t i_rate,
  output logic  o_stb,
  output logic  o_last,
  output rail_t o_i,
  output rail_t o_q
);

  localparam int N  = `DDC_CIC_N;
  localparam int NR = 2;  // rail 0 is I, rail 1 is Q
  localparam rail_t RAIL_MIN = {1'b1, {(`DDC_SAMPLE_W-1){1'b0}}};
  localparam rail_t RAIL_MAX = ~RAIL_MIN;

  rail_t      in_rail   [NR];
  acc_t       integ     [NR][N];
  acc_t       integ_nxt [NR][N];
  acc_t       comb_dly  [NR][N];
  acc_t       comb_in   [NR][N+1];  // comb_in[r][N] is the comb output
  acc_t       norm      [NR];
  rail_t      sat       [NR];
  logic [5:0] shift;
  logic       dump_d;
  logic       last_d;
  logic       win_last;  // a last seen earlier in this window

  function automatic logic [3:0] ceil_log2(input rate_t r);
    logic [3:0] res;
    res = '0;
    for (int b = 0; b < `DDC_RATE_W; b++) begin
      if ((9'd1 << b) < {1'b0, r}) begin
        res = 4'(b + 1);
      end
    end
    return res;
  endfunction

  assign in_rail[0] = i_i;
  assign in_rail[1] = i_q;

  always_comb begin
    for (int r = 0; r < NR; r++) begin
      integ_nxt[r][0] = integ[r][0] + acc_t'(in_rail[r]);
      for (int k = 1; k < N; k++) begin
        integ_nxt[r][k] = integ[r][k] + integ_nxt[r][k-1];  // no pipeline delay
      end
      comb_in[r][0] = integ[r][N-1];
      for (int k = 0; k < N; k++) begin
        comb_in[r][k+1] = comb_in[r][k] - comb_dly[r][k];
      end
      norm[r] = comb_in[r][N] >>> shift;
      if (&norm[r][`DDC_CIC_ACC_W-1:`DDC_SAMPLE_W-1] ||
          ~|norm[r][`DDC_CIC_ACC_W-1:`DDC_SAMPLE_W-1]) begin
        sat[r] = norm[r][`DDC_SAMPLE_W-1:0];
      end else begin
        sat[r] = norm[r][`DDC_CIC_ACC_W-1] ? RAIL_MIN : RAIL_MAX;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear || i_rate_apply) begin
      for (int r = 0; r < NR; r++) begin
        for (int k = 0; k < N; k++) begin
          integ[r][k]    <= '0;
          comb_dly[r][k] <= '0;
        end
      end
      dump_d   <= 1'b0;
      last_d   <= 1'b0;
      win_last <= 1'b0;
      o_stb    <= 1'b0;
      o_last   <= 1'b0;
    end else begin
      if (i_stb) begin
        for (int r = 0; r < NR; r++) begin
          for (int k = 0; k < N; k++) begin
            integ[r][k] <= integ_nxt[r][k];
          end
        end
        win_last <= i_dump ? 1'b0 : (win_last || i_last);
      end
      dump_d <= i_stb && i_dump;
      last_d <= i_stb && i_dump && (win_last || i_last);
      if (dump_d) begin
        for (int r = 0; r < NR; r++) begin
          for (int k = 0; k < N; k++) begin
            comb_dly[r][k] <= comb_in[r][k];
          end
        end
      end
      o_stb  <= dump_d;
      o_last <= last_d;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      shift <= '0;  // rate 1 after reset
    end else if (i_rate_apply) begin
      shift <= {ceil_log2(i_rate), 2'b00};
    end
  end

  always_ff @(posedge clk) begin
    if (dump_d) begin
      o_i <= sat[0];
      o_q <= sat[1];
    end
  end

endmodule

`default_nettype wire

// File: hw/iq_input_mux.sv
// ====================
// I in the upper half of the input word, Q in the lower
// real mode zeroes Q after the swap
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "ddc_consts.svh"

module iq_input_mux
  import ddc_sample_pkg::*;
(
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     i_clear,
  input  wire                     i_stb,
  input  wire                     i_last,
  input  wire [2*`DDC_IN_W-1:0]   i_sample,
  input  wire                     i_swap_iq,
  input  wire                     i_real_mode,
  output logic                    o_stb,
  output logic                    o_last,
  output rail_t                   o_i,
  output rail_t                   o_q
);

  rail_t in_i;
  rail_t in_q;

  assign in_i = {i_sample[2*`DDC_IN_W-1:`DDC_IN_W], {`DDC_PAD_W{1'b0}}};
  assign in_q = {i_sample[`DDC_IN_W-1:0], {`DDC_PAD_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_stb  <= 1'b0;
      o_last <= 1'b0;
    end else begin
      o_stb  <= i_stb;
      o_last <= i_stb && i_last;
    end
  end

  always_ff @(posedge clk) begin
    if (i_stb) begin
      o_i <= i_swap_iq ? in_q : in_i;
      o_q <= i_real_mode ? '0 : (i_swap_iq ? in_i : in_q);
    end
  end

endmodule

`default_nettype wire

// File: hw/decim_counter.sv
// ====================
// marks the sample closing each window of i_rate samples
// o_dump is combinational on i_stb
// ====================
`timescale 1ns/1ps
`default_nettype none

module decim_counter
  import ddc_sample_pkg::*;
(
  input  wire   clk,
  input  wire   reset,
  input  wire   i_clear,
  input  wire   i_stb,
  input  wire   i_rate_apply,
  input  wire rate_t i_rate,
  output logic  o_dump
);

  rate_t cnt;
  logic  win_end;

  assign win_end = (cnt == i_rate - rate_t'(1));
  assign o_dump  = i_stb && win_end && !i_rate_apply;  // cic drops this sample too

  always_ff @(posedge clk) begin
    if (reset || i_clear || i_rate_apply) begin
      cnt <= '0;
    end else if (i_stb) begin
      cnt <= win_end ? '0 : cnt + rate_t'(1);
    end
  end

  // count is only stale in the cycle the new rate arrives
  assert property (@(posedge clk) disable iff (reset)
    !i_rate_apply |-> (cnt < i_rate));

endmodule

`default_nettype wire

// File: hw/rate_control_fsm.sv
// ====================
// rate changes during a stream are held until clear
// a requested rate of 0 is applied as 1
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "ddc_consts.svh"

module rate_control_fsm
  import ddc_cfg_pkg::*;
  import ddc_sample_pkg::*;
(
  input  wire   clk,
  input  wire   reset,
  input  wire   i_clear,
  input  wire   i_in_stb,
  input  wire   i_rate_written,
  input  wire rate_t i_rate_req,
  output logic  o_rate_apply,
  output rate_t o_rate
);

  rate_state_e state;
  logic        apply_now;
  rate_t       rate_safe;

  assign rate_safe = (i_rate_req == '0) ? rate_t'(1) : i_rate_req;

  // a write together with the first sample counts as a write during flow
  assign apply_now = i_clear ? (state == RATE_PENDING || i_rate_written)
                             : (state == RATE_IDLE && i_rate_written && !i_in_stb);

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= RATE_IDLE;
      o_rate_apply <= 1'b0;
      o_rate       <= rate_t'(`DDC_RATE_RESET);
    end else begin
      o_rate_apply <= apply_now;
      if (apply_now) begin
        o_rate <= rate_safe;
      end
      if (i_clear) begin
        state <= RATE_IDLE;
      end else begin
        case (state)
          RATE_IDLE: begin
            if (i_in_stb) begin
              state <= i_rate_written ? RATE_PENDING : RATE_ACTIVE;
            end
          end
          RATE_ACTIVE: begin
            if (i_rate_written) begin
              state <= RATE_PENDING;
            end
          end
          RATE_PENDING: state <= RATE_PENDING;  // only clear leaves
          default:      state <= RATE_IDLE;
        endcase
      end
    end
  end

  // the chain must never see a rate change mid stream
  assert property (@(posedge clk) disable iff (reset)
    o_rate_apply |-> (state != RATE_ACTIVE));

  assert property (@(posedge clk) disable iff (reset) o_rate != '0);

endmodule

`default_nettype wire

// File: hw/ddc_settings.sv
// ====================
// settings bus decode, writes land one cycle after the strobe
// unknown addresses are ignored
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "ddc_consts.svh"

module ddc_settings
  import ddc_cfg_pkg::*;
  import ddc_sample_pkg::*;
(
  input  wire            clk,
  input  wire            reset,
  input  wire            i_set_stb,
  input  wire reg_addr_e i_set_addr,
  input  wire [31:0]     i_set_data,
  output scale_t         o_scale,
  output rate_t          o_rate_req,
  output logic           o_rate_written,
  output logic           o_swap_iq,
  output logic           o_real_mode
);

  always_ff @(posedge clk) begin
    if (reset) begin
      o_scale        <= scale_t'(`DDC_SCALE_RESET);
      o_rate_req     <= rate_t'(`DDC_RATE_RESET);
      o_rate_written <= 1'b0;
      o_swap_iq      <= 1'b0;
      o_real_mode    <= 1'b0;
    end else begin
      o_rate_written <= i_set_stb && (i_set_addr == ADDR_DECIM);
      if (i_set_stb) begin
        case (i_set_addr)
          ADDR_SCALE: o_scale    <= i_set_data[`DDC_SCALE_W-1:0];
          ADDR_DECIM: o_rate_req <= i_set_data[`DDC_RATE_W-1:0];  // applied by the fsm
          ADDR_MUX: begin
            o_swap_iq   <= i_set_data[0];
            o_real_mode <= i_set_data[1];
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/ddc_sample_pkg.sv
// ====================
// sample word types along the chain
// all rails are two's complement
// ====================
`default_nettype none

`include "ddc_consts.svh"

package ddc_sample_pkg;

  typedef logic signed [`DDC_SAMPLE_W-1:0]  rail_t;      // internal rail
  typedef logic signed [`DDC_CIC_ACC_W-1:0] acc_t;       // cic integrator / comb
  typedef logic signed [`DDC_OUT_W-1:0]     out_rail_t;  // output rail
  typedef logic signed [`DDC_SCALE_W-1:0]   scale_t;     // gain, 1.0 = 2**14
  typedef logic [`DDC_RATE_W-1:0]           rate_t;      // decimation rate

endpackage

`default_nettype wire

// File: hw/ddc_cfg_pkg.sv
// ====================
// settings addresses and rate control states
// ====================
`default_nettype none

package ddc_cfg_pkg;

  // settings bus register map
  typedef enum logic [7:0] {
    ADDR_SCALE = 8'd1,
    ADDR_DECIM = 8'd2,
    ADDR_MUX   = 8'd3
  } reg_addr_e;

  typedef enum logic [1:0] {
    RATE_IDLE    = 2'd0,  // no samples since last clear
    RATE_ACTIVE  = 2'd1,  // samples flowing
    RATE_PENDING = 2'd2   // new rate waits for clear
  } rate_state_e;

endpackage

`default_nettype wire

// File: include/ddc_consts.svh
// ====================
// widths, stage count and reset values of the receive chain
// the accumulator width must stay sample width plus stages times rate width
// ====================
`ifndef DDC_CONSTS_SVH
`define DDC_CONSTS_SVH

`define DDC_IN_W        16  // each input rail
`define DDC_SAMPLE_W    24  // internal rail
`define DDC_PAD_W       8   // zeros appended below input rails
`define DDC_CIC_N       4   // cic stages
`define DDC_RATE_W      8   // rate field
`define DDC_CIC_ACC_W   56  // sample width + stages * rate width
`define DDC_SCALE_W     18  // scale factor
`define DDC_SCALE_SHIFT 14  // product shift
`define DDC_OUT_W       16  // output rail

`define DDC_RATE_RESET  1   // no decimation after reset
`define DDC_SCALE_RESET 0

`endif
